// ==== core_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, fetch buffer sizing, RV32I opcode and
// function codes, ALU operation encoding
////////////////////////////////////////////////////////////

package core_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath and buffer sizing
  ////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;
  // Register index width, x0..x31
  localparam int unsigned REG_ADDR_W = 5;
  // Fetch buffer entries
  localparam int unsigned FIFO_DEPTH = 4;
  // Must hold 0..FIFO_DEPTH inclusive
  localparam int unsigned FIFO_CNT_W = 3;
  // Sequential fetch step, word aligned
  localparam logic [XLEN-1:0] INSTR_STEP = 32'd4;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 selecting SUB over ADD
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B  // LUI, operand b straight through
  } alu_op_e;

endpackage

// ==== fetch_unit.sv ====
////////////////////////////////////////////////////////////
// Instruction fetch: request PC, response PC tagging and
// outstanding request credit against the fetch buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fetch_unit (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [core_pkg::XLEN-1:0]      boot_addr_i,
  input  logic                           fetch_enable_i,
  // Instruction bus
  output logic                           instr_req_o,
  output logic [core_pkg::XLEN-1:0]      instr_addr_o,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]      instr_rdata_i,
  // Fetch buffer side
  input  logic [core_pkg::FIFO_CNT_W-1:0] fifo_count_i,
  output logic                           push_o,
  output logic [core_pkg::XLEN-1:0]      push_instr_o,
  output logic [core_pkg::XLEN-1:0]      push_pc_o
);

  logic                            run_q;
  logic [core_pkg::XLEN-1:0]       req_pc_q;
  logic [core_pkg::XLEN-1:0]       resp_pc_q;
  logic [core_pkg::FIFO_CNT_W-1:0] outst_q;
  logic [core_pkg::FIFO_CNT_W:0]   inflight;
  logic                            credit;
  logic                            grant;

  // Words in flight plus words parked in the buffer
  assign inflight = {1'b0, outst_q} + {1'b0, fifo_count_i};
  assign credit   = inflight < (core_pkg::FIFO_CNT_W + 1)'(core_pkg::FIFO_DEPTH);

  // Request only with room guaranteed for the response
  assign instr_req_o  = run_q && fetch_enable_i && credit;
  assign instr_addr_o = req_pc_q;
  assign grant        = instr_req_o && instr_gnt_i;

  // Responses go straight into the buffer
  assign push_o       = instr_rvalid_i;
  assign push_instr_o = instr_rdata_i;
  assign push_pc_o    = resp_pc_q;

  ////////////////////////////////////////////////////////////
  // PC and credit state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q     <= 1'b0;
      req_pc_q  <= boot_addr_i;
      resp_pc_q <= boot_addr_i;
      outst_q   <= '0;
    end else begin
      // First request one cycle out of reset
      run_q <= 1'b1;
      // Address held until the grant arrives
      if (grant) begin
        req_pc_q <= req_pc_q + core_pkg::INSTR_STEP;
      end
      // In-order responses, so this PC tracks the returned word
      if (instr_rvalid_i) begin
        resp_pc_q <= resp_pc_q + core_pkg::INSTR_STEP;
      end
      case ({grant, instr_rvalid_i})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;
      endcase
    end
  end

endmodule

// ==== fetch_fifo.sv ====
////////////////////////////////////////////////////////////
// Circular buffer of fetched instruction words and PCs
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fetch_fifo (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            push_i,
  input  logic [core_pkg::XLEN-1:0]       push_instr_i,
  input  logic [core_pkg::XLEN-1:0]       push_pc_i,
  input  logic                            pop_i,
  output logic [core_pkg::XLEN-1:0]       instr_o,
  output logic [core_pkg::XLEN-1:0]       pc_o,
  output logic                            empty_o,
  output logic [core_pkg::FIFO_CNT_W-1:0] count_o
);

  // Storage, no reset needed
  logic [core_pkg::XLEN-1:0] instr_mem [core_pkg::FIFO_DEPTH];
  logic [core_pkg::XLEN-1:0] pc_mem    [core_pkg::FIFO_DEPTH];

  // Pointers wrap naturally, depth is a power of two
  logic [$clog2(core_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(core_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [core_pkg::FIFO_CNT_W-1:0]         cnt_q;

  // Head entry shown directly
  assign instr_o = instr_mem[rd_ptr_q];
  assign pc_o    = pc_mem[rd_ptr_q];
  assign empty_o = cnt_q == '0;
  assign count_o = cnt_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      instr_mem[wr_ptr_q] <= push_instr_i;
      pc_mem[wr_ptr_q]    <= push_pc_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// ==== register_file.sv ====
////////////////////////////////////////////////////////////
// Integer register file, x0 hardwired to zero
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module register_file (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i
);

  // x1..x31 only, no storage behind x0
  logic [core_pkg::XLEN-1:0] regs_q [1:31];

  // Read ports, address 0 falls through to zero
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    for (int i = 1; i < 32; i++) begin
      if (raddr_a_i == core_pkg::REG_ADDR_W'(i)) begin
        rdata_a_o = regs_q[i];
      end
      if (raddr_b_i == core_pkg::REG_ADDR_W'(i)) begin
        rdata_b_o = regs_q[i];
      end
    end
  end

  // Write port, writes to x0 match no entry
  always_ff @(posedge clk_i) begin
    for (int i = 1; i < 32; i++) begin
      if (rst_i) begin
        regs_q[i] <= '0;
      end else if (we_i && waddr_i == core_pkg::REG_ADDR_W'(i)) begin
        regs_q[i] <= wdata_i;
      end
    end
  end

endmodule

// ==== exec_unit.sv ====
////////////////////////////////////////////////////////////
// Decode, immediates, ALU, writeback and retire reporting
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module exec_unit (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Fetch buffer head
  input  logic                            empty_i,
  input  logic [core_pkg::XLEN-1:0]       instr_i,
  input  logic [core_pkg::XLEN-1:0]       pc_i,
  output logic                            pop_o,
  // Register file
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [core_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]       rdata_b_i,
  output logic                            rf_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
  // Retire port
  output logic                            retire_valid_o,
  output logic [core_pkg::XLEN-1:0]       retire_pc_o,
  output logic                            retire_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [core_pkg::XLEN-1:0]       retire_data_o
);

  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [core_pkg::XLEN-1:0]       imm_i;
  logic [core_pkg::XLEN-1:0]       imm_u;
  logic [core_pkg::XLEN-1:0]       operand_b;
  logic [core_pkg::XLEN-1:0]       result;
  logic                            wr_en;
  core_pkg::alu_op_e               alu_op;

  ////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////

  assign opcode    = instr_i[6:0];
  assign rd        = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];
  assign funct7    = instr_i[31:25];

  // I type sign extended, U type upper 20 bits
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};

  // Single cycle execute, never stalls
  assign pop_o = !empty_i;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = core_pkg::ALU_ADD;
    operand_b = rdata_b_i;
    wr_en     = 1'b0;
    case (opcode)
      core_pkg::OPC_LUI: begin
        alu_op    = core_pkg::ALU_PASS_B;
        operand_b = imm_u;
        wr_en     = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        operand_b = imm_i;
        wr_en     = 1'b1;
        case (funct3)
          core_pkg::F3_ADD: alu_op = core_pkg::ALU_ADD;
          core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
          // Shifts and compares unsupported
          default:          wr_en  = 1'b0;
        endcase
      end
      core_pkg::OPC_OP: begin
        // Plain funct7 for all but SUB
        wr_en = funct7 == 7'b0;
        case (funct3)
          core_pkg::F3_ADD: begin
            if (funct7 == core_pkg::F7_SUB) begin
              alu_op = core_pkg::ALU_SUB;
              wr_en  = 1'b1;
            end
          end
          core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
          default:          wr_en  = 1'b0;
        endcase
      end
      // Anything else retires as a no-op
      default: wr_en = 1'b0;
    endcase
  end

  // ALU
  always_comb begin
    case (alu_op)
      core_pkg::ALU_SUB:    result = rdata_a_i - operand_b;
      core_pkg::ALU_AND:    result = rdata_a_i & operand_b;
      core_pkg::ALU_OR:     result = rdata_a_i | operand_b;
      core_pkg::ALU_XOR:    result = rdata_a_i ^ operand_b;
      core_pkg::ALU_PASS_B: result = operand_b;
      default:              result = rdata_a_i + operand_b;
    endcase
  end

  // Writeback lands on the same edge as retire
  assign rf_we_o    = pop_o && wr_en && rd != '0;
  assign rf_waddr_o = rd;
  assign rf_wdata_o = result;

  ////////////////////////////////////////////////////////////
  // Retire port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_valid_o <= 1'b0;
      retire_we_o    <= 1'b0;
    end else begin
      retire_valid_o <= pop_o;
      retire_we_o    <= rf_we_o;
    end
  end

  // Payload only, qualified by retire_valid_o
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      retire_pc_o   <= pc_i;
      retire_rd_o   <= rd;
      retire_data_o <= result;
    end
  end

endmodule

// ==== mini_core.sv ====
////////////////////////////////////////////////////////////
// Core top level: fetch unit, fetch buffer, execute unit
// and register file
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mini_core (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [core_pkg::XLEN-1:0]       boot_addr_i,
  input  logic                            fetch_enable_i,
  // Instruction bus
  output logic                            instr_req_o,
  output logic [core_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]       instr_rdata_i,
  // Retire trace
  output logic                            retire_valid_o,
  output logic [core_pkg::XLEN-1:0]       retire_pc_o,
  output logic                            retire_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [core_pkg::XLEN-1:0]       retire_data_o
);

  // Fetch to buffer
  logic                            push;
  logic [core_pkg::XLEN-1:0]       push_instr;
  logic [core_pkg::XLEN-1:0]       push_pc;
  logic [core_pkg::FIFO_CNT_W-1:0] fifo_count;

  // Buffer to execute
  logic                            pop;
  logic                            fifo_empty;
  logic [core_pkg::XLEN-1:0]       fifo_instr;
  logic [core_pkg::XLEN-1:0]       fifo_pc;

  // Execute to register file
  logic [core_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [core_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [core_pkg::XLEN-1:0]       rdata_a;
  logic [core_pkg::XLEN-1:0]       rdata_b;
  logic                            rf_we;
  logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [core_pkg::XLEN-1:0]       rf_wdata;

  ////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////

  fetch_unit fetch_unit_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fifo_count_i   ( fifo_count     ),
    .push_o         ( push           ),
    .push_instr_o   ( push_instr     ),
    .push_pc_o      ( push_pc        )
  );

  fetch_fifo fetch_fifo_i (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .push_i       ( push       ),
    .push_instr_i ( push_instr ),
    .push_pc_i    ( push_pc    ),
    .pop_i        ( pop        ),
    .instr_o      ( fifo_instr ),
    .pc_o         ( fifo_pc    ),
    .empty_o      ( fifo_empty ),
    .count_o      ( fifo_count )
  );

  ////////////////////////////////////////////////////////////
  // Execute and registers
  ////////////////////////////////////////////////////////////

  exec_unit exec_unit_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .empty_i        ( fifo_empty     ),
    .instr_i        ( fifo_instr     ),
    .pc_i           ( fifo_pc        ),
    .pop_o          ( pop            ),
    .raddr_a_o      ( raddr_a        ),
    .raddr_b_o      ( raddr_b        ),
    .rdata_a_i      ( rdata_a        ),
    .rdata_b_i      ( rdata_b        ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_we_o    ( retire_we_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_data_o  ( retire_data_o  )
  );

  register_file register_file_i (
    .clk_i     ( clk_i    ),
    .rst_i     ( rst_i    ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

endmodule

// ==== tb_mini_core.sv ====
////////////////////////////////////////////////////////////
// mini_core testbench with clock, reset, instruction memory,
// random grant, delayed responses and retire checks
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mini_core;

  localparam logic [31:0] BOOT_ADDR      = 32'h8000_0080;
  localparam int          MAX_INSTR      = 32;
  // Stim columns are instruction, write flag, rd and value
  localparam int          STIM_COLS      = 4;
  localparam int          DISABLE_AFTER  = 8;
  localparam int          DISABLE_CYCLES = 20;

  logic                                clk_i;
  logic                                rst_i;
  logic [core_pkg::XLEN-1:0]           boot_addr_i;
  logic                                fetch_enable_i;
  logic                                instr_req_o;
  logic [core_pkg::XLEN-1:0]           instr_addr_o;
  logic                                instr_gnt_i;
  logic                                instr_rvalid_i;
  logic [core_pkg::XLEN-1:0]           instr_rdata_i;
  logic                                retire_valid_o;
  logic [core_pkg::XLEN-1:0]           retire_pc_o;
  logic                                retire_we_o;
  logic [core_pkg::REG_ADDR_W-1:0]     retire_rd_o;
  logic [core_pkg::XLEN-1:0]           retire_data_o;

  logic [31:0] stim_mem [MAX_INSTR*STIM_COLS];
  int          n_instr;
  int          accepted_cnt;
  int          answered_cnt;
  int          retired_cnt;
  int          cycle_cnt;
  logic [15:0] lfsr_q = 16'd15;

  mini_core mini_core_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_we_o    ( retire_we_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_data_o  ( retire_data_o  )
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR with taps for a maximal 16-bit sequence
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit with the first bit in the MSB
  function automatic int unsigned take_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      v      = (v << 1) | 32'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Program words from the stim file and address-derived filler past the end
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - BOOT_ADDR;
    if (addr >= BOOT_ADDR && int'(offset >> 2) < n_instr) begin
      return stim_mem[STIM_COLS*int'(offset >> 2)];
    end
    // MISC-MEM opcode that retires with no write
    return {addr[31:7] ^ addr[24:0], 7'b0001111};
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > 20 * n_instr + 100) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions retired",
               cycle_cnt, retired_cnt, n_instr);
      $display(">>> FAIL");
      $fatal(1, "simulation did not finish in time");
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////

  initial begin : bus_model
    int          now;
    int          delay;
    int          due;
    int          last_due;
    logic        held;
    logic [31:0] held_addr;
    logic [31:0] addr;
    int          due_q[$];
    logic [31:0] addr_q[$];
    now      = 0;
    last_due = -1;
    held     = 1'b0;
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    instr_rdata_i  <= '0;
    forever begin
      @(posedge clk_i);
      now++;
      // Accepted request queued with a 1..3 cycle response delay
      if (instr_req_o && instr_gnt_i) begin
        compare($sformatf("request %0d address", accepted_cnt),
                BOOT_ADDR + 32'(4 * accepted_cnt), instr_addr_o);
        delay = int'(take_bits(2) % 3) + 1;
        due   = now + delay - 1;
        // One response per cycle in order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        addr_q.push_back(instr_addr_o);
        accepted_cnt++;
      end
      // Back-pressure keeps the address
      if (held && instr_req_o) begin
        compare("address held while grant withheld", held_addr, instr_addr_o);
      end
      held      = instr_req_o && !instr_gnt_i;
      held_addr = instr_addr_o;
      if (!rst_i && !fetch_enable_i) begin
        compare("request raised while fetch disabled", 32'd0, 32'(instr_req_o));
      end
      if (instr_rvalid_i) begin
        answered_cnt++;
      end
      compare("outstanding requests within buffer depth", 32'd1,
              32'(accepted_cnt - answered_cnt <= int'(core_pkg::FIFO_DEPTH)));
      // Drive the oldest due response
      if (due_q.size() > 0 && due_q[0] <= now) begin
        addr = addr_q.pop_front();
        void'(due_q.pop_front());
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(addr);
      end else begin
        instr_rvalid_i <= 1'b0;
      end
      instr_gnt_i <= take_bits(1) != 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Retire checks against the stim file
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int base;
    if (!rst_i && retire_valid_o && retired_cnt < n_instr) begin
      base = STIM_COLS * retired_cnt;
      compare($sformatf("instr %0d retire pc", retired_cnt),
              BOOT_ADDR + 32'(4 * retired_cnt), retire_pc_o);
      compare($sformatf("instr %0d retire we", retired_cnt),
              stim_mem[base+1], 32'(retire_we_o));
      compare($sformatf("instr %0d retire rd", retired_cnt),
              stim_mem[base+2], 32'(retire_rd_o));
      // Data only meaningful with a write
      if (stim_mem[base+1][0]) begin
        compare($sformatf("instr %0d retire data", retired_cnt),
                stim_mem[base+3], retire_data_o);
      end
      retired_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_i          <= 1'b1;
    boot_addr_i    <= BOOT_ADDR;
    fetch_enable_i <= 1'b1;
    // Unused flag column marks the end of the program
    for (int i = 0; i < MAX_INSTR * STIM_COLS; i++) begin
      stim_mem[i] = 32'hFFFF_FFFF;
    end
    $readmemh("core_stim.txt", stim_mem);
    n_instr = 0;
    while (n_instr < MAX_INSTR && stim_mem[STIM_COLS*n_instr+1] != 32'hFFFF_FFFF) begin
      n_instr++;
    end
    if (n_instr == 0) begin
      $display("Stimulus file core_stim.txt holds no instructions");
      $display(">>> FAIL");
      $fatal(1, "no stimulus loaded");
    end
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    // Fetch enable dropped mid-program
    wait (accepted_cnt >= DISABLE_AFTER);
    @(posedge clk_i);
    fetch_enable_i <= 1'b0;
    repeat (DISABLE_CYCLES) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    wait (retired_cnt == n_instr);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== core_stim.txt ====
// instr     we  rd  value
// one instruction per line, in program order from the boot address
123450B7 1 01 12345000  // lui  x1, 0x12345
FFB00113 1 02 FFFFFFFB  // addi x2, x0, -5
002081B3 1 03 12344FFB  // add  x3, x1, x2
40118233 1 04 FFFFFFFB  // sub  x4, x3, x1
3C500293 1 05 000003C5  // addi x5, x0, 0x3c5
0051F333 1 06 000003C1  // and  x6, x3, x5
0050E3B3 1 07 123453C5  // or   x7, x1, x5
0033C433 1 08 00001C3E  // xor  x8, x7, x3
00108013 0 00 00000000  // addi x0, x1, 1 discarded
0050A493 0 09 00000000  // slti x9, x1, 5 unsupported
00800533 1 0a 00001C3E  // add  x10, x0, x8
405005B3 1 0b FFFFFC3B  // sub  x11, x0, x5
000000EF 0 01 00000000  // jal  x1, 0 unsupported
7FF08613 1 0c 123457FF  // addi x12, x1, 2047
00C606B3 1 0d 2468AFFE  // add  x13, x12, x12
FFFFF737 1 0e FFFFF000  // lui  x14, 0xfffff
00A767B3 1 0f FFFFFC3E  // or   x15, x14, x10
401080B3 1 01 00000000  // sub  x1, x1, x1
00F0C833 1 10 FFFFFC3E  // xor  x16, x1, x15

// ==== flist.f ====
core_pkg.sv
fetch_unit.sv
fetch_fifo.sv
register_file.sv
exec_unit.sv
mini_core.sv
tb_mini_core.sv

// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = tb_mini_core
RTL_TOP = mini_core
FLIST   = flist.f
BUILD   = obj_dir
LOG     = sim.log

SRCS = $(shell cat $(FLIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
